// File: compile.f
hw/ntt_params_pkg.sv
hw/ntt_ctrl_pkg.sv
hw/ntt_share_arbiter.sv
hw/poly_mem.sv
hw/pointwise_engine.sv
hw/ntt_subsystem_top.sv
test/ntt_subsystem_checker.sv
test/ntt_subsystem_tb.sv

// File: Makefile
# Verilator simulation of the shared pointwise polynomial unit

VERILATOR ?= verilator
TOP       ?= ntt_subsystem_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf $(OBJ_DIR)

// File: test/ntt_testdata.txt
# Header line, all hex: port (2 pulses both ports) mode a_base b_base
# Then eight coefficients per line: A, B or sampler data, initial D, expected D
0 1 00 10
000003 000100 001000 7FE000 7FE000 400000 000000 0007D0
000005 000100 001000 7FE000 000002 000002 123456 0007D0
000011 000022 000033 000044 000055 000066 000077 000088
00000F 010000 003FFE 000001 7FDFFF 001FFF 000000 3D0900
1 5 20 28
000001 7FE000 7FE000 400000 3FF000 000000 123456 7FDFFF
000002 000001 7FE000 400000 3FF001 000000 000000 000003
0000AA 0000BB 0000CC 0000DD 0000EE 0000FF 000100 000101
000003 000000 7FDFFF 001FFF 000000 000000 123456 000001
0 6 08 20
000005 000000 000000 7FE000 000001 123456 000010 400000
000003 000001 7FE000 7FE000 000002 123456 000020 7FE000
000101 000202 000303 000404 000505 000606 000707 000808
000002 7FE000 000001 000000 7FE000 000000 7FDFF1 400001
0 2 00 10
000002 000003 7FE000 000100 001000 000000 000001 7FE000
000003 000004 000001 000100 001000 000005 7FE000 7FE000
000001 7FE000 000002 000000 7FC002 000009 000001 7FE000
000007 00000B 000001 010000 001FFF 000009 000000 000000
0 3 20 30
000007 000100 7FE000 001000 000002 000000 0003E8 400000
000006 000200 000003 001000 7FE000 055555 0003E8 000004
000010 000020 000030 000040 000050 000060 000070 000080
00002A 020000 7FDFFE 003FFE 7FDFFF 000000 0F4240 003FFE
1 4 08 10
000001 000002 000003 000004 7FE000 000010 001000 000000
000010 000020 000030 000040 000001 000010 001000 7FE000
000001 000002 000003 000004 000001 7FDF01 000000 000123
000011 000042 000093 000104 000000 000000 003FFE 000123
2 1 00 30
000001 000002 000003 000004 000005 000006 000007 000008
000008 000007 000006 000005 000004 000003 000002 000001
000201 000202 000203 000204 000205 000206 000207 000208
000008 00000E 000012 000014 000014 000012 00000E 000008

// File: test/ntt_subsystem_tb.sv
// *************************************************************************
// Testbench of the shared pointwise polynomial unit
//   Reads job records, loads memory through the host port
//   Runs jobs on both controller ports with sampler valid gaps
//   Checks status timing, ownership and destination contents
// *************************************************************************

`timescale 1ns/100ps

module ntt_subsystem_tb;

  localparam int MAX_REC        = 16;
  localparam int RESET_CYCLES   = 8;
  localparam int CYCLES_PER_REC = 400;
  localparam int JOB_LATENCY    = 11;

  logic                            clk;
  logic                            reset_n;
  logic [1:0]                      ntt_enable;
  ntt_ctrl_pkg::ntt_mode_e [1:0]   ntt_mode;
  ntt_params_pkg::mem_addr_t [1:0] ntt_base;
  ntt_params_pkg::mem_addr_t [1:0] pwo_base;
  logic [1:0]                      sampler_dv;
  ntt_params_pkg::coeff_t          sampler_data;
  logic [1:0]                      ntt_busy;
  logic [1:0]                      ntt_done;
  logic                            host_we;
  logic                            host_re;
  ntt_params_pkg::mem_addr_t       host_addr;
  ntt_params_pkg::coeff_t          host_wdata;
  ntt_params_pkg::coeff_t          host_rdata;

  // Record fields, value sets are A, B or sampler, initial D, expected D
  int                        num_rec;
  bit                        records_ready;
  logic [1:0]                rec_port [MAX_REC];
  ntt_ctrl_pkg::ntt_mode_e   rec_mode [MAX_REC];
  ntt_params_pkg::mem_addr_t rec_a [MAX_REC];
  ntt_params_pkg::mem_addr_t rec_b [MAX_REC];
  ntt_params_pkg::coeff_t    rec_vals [MAX_REC][4][ntt_params_pkg::POLY_N];

  ntt_subsystem_top dut_i (
    .clk            (clk),
    .reset_n        (reset_n),
    .ntt_enable_i   (ntt_enable),
    .ntt_mode_i     (ntt_mode),
    .ntt_base_i     (ntt_base),
    .pwo_base_i     (pwo_base),
    .sampler_dv_i   (sampler_dv),
    .sampler_data_i (sampler_data),
    .ntt_busy_o     (ntt_busy),
    .ntt_done_o     (ntt_done),
    .host_we_i      (host_we),
    .host_re_i      (host_re),
    .host_addr_i    (host_addr),
    .host_wdata_i   (host_wdata),
    .host_rdata_o   (host_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("ERRORS FOUND");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic check_coeff(input string name, input ntt_params_pkg::coeff_t exp,
                             input ntt_params_pkg::coeff_t act);
    if (act !== exp) begin
      stop_with_error($sformatf("mismatch at %0t: %s expected %h, got %h",
                                $time, name, exp, act));
    end
  endtask

  task automatic check_status(input string name, input logic [1:0] exp, input logic [1:0] act);
    if (act !== exp) begin
      stop_with_error($sformatf("mismatch at %0t: %s expected %b, got %b",
                                $time, name, exp, act));
    end
  endtask

  task automatic check_latency(input string name, input int exp, input int act);
    if (act != exp) begin
      stop_with_error($sformatf("mismatch at %0t: %s expected %0d, got %0d",
                                $time, name, exp, act));
    end
  endtask

  // Skips comment and blank lines, empty result at end of file
  task automatic next_data_line(input int fd, output string line);
    int n;
    bit skip;
    skip = 1'b1;
    line = "";
    while (skip && !$feof(fd)) begin
      n = $fgets(line, fd);
      skip = (n == 0) || (line.getc(0) == "#") || (line.getc(0) == "\n");
    end
    if (skip) line = "";
  endtask

  task automatic read_coeff_line(input int fd, input int r, input int kind);
    string line;
    int n;
    next_data_line(fd, line);
    n = $sscanf(line, "%h %h %h %h %h %h %h %h",
                rec_vals[r][kind][0], rec_vals[r][kind][1],
                rec_vals[r][kind][2], rec_vals[r][kind][3],
                rec_vals[r][kind][4], rec_vals[r][kind][5],
                rec_vals[r][kind][6], rec_vals[r][kind][7]);
    if (n != ntt_params_pkg::POLY_N) begin
      stop_with_error($sformatf("record %0d has a short coefficient line", r));
    end
  endtask

  task automatic load_records();
    int fd;
    int n;
    int kind;
    string line;
    logic [31:0] f_port;
    logic [31:0] f_mode;
    logic [31:0] f_a;
    logic [31:0] f_b;
    fd = $fopen("test/ntt_testdata.txt", "r");
    if (fd == 0) stop_with_error("cannot open test/ntt_testdata.txt");
    num_rec = 0;
    next_data_line(fd, line);
    while (line.len() != 0 && num_rec < MAX_REC) begin
      n = $sscanf(line, "%h %h %h %h", f_port, f_mode, f_a, f_b);
      if (n != 4) stop_with_error($sformatf("record %0d has a bad header line", num_rec));
      rec_port[num_rec] = f_port[1:0];
      rec_mode[num_rec] = ntt_ctrl_pkg::ntt_mode_e'(f_mode[2:0]);
      rec_a[num_rec]    = f_a[5:0];
      rec_b[num_rec]    = f_b[5:0];
      for (kind = 0; kind < 4; kind++) read_coeff_line(fd, num_rec, kind);
      num_rec++;
      next_data_line(fd, line);
    end
    $fclose(fd);
    if (num_rec == 0) stop_with_error("no test records in test/ntt_testdata.txt");
  endtask

  task automatic load_region(input ntt_params_pkg::mem_addr_t base, input int r,
                             input int kind, input bit zero_fill);
    int i;
    for (i = 0; i < ntt_params_pkg::POLY_N; i++) begin
      @(posedge clk);
      host_we    <= 1'b1;
      host_addr  <= base + ntt_params_pkg::mem_addr_t'(i);
      host_wdata <= zero_fill ? '0 : rec_vals[r][kind][i];
    end
    @(posedge clk);
    host_we <= 1'b0;
  endtask

  task automatic check_region(input int r);
    int i;
    ntt_params_pkg::mem_addr_t addr;
    for (i = 0; i < ntt_params_pkg::POLY_N; i++) begin
      addr = rec_b[r] + ntt_params_pkg::DEST_OFFSET + ntt_params_pkg::mem_addr_t'(i);
      @(posedge clk);
      host_re   <= 1'b1;
      host_addr <= addr;
      @(posedge clk);
      host_re <= 1'b0;
      @(posedge clk);
      check_coeff($sformatf("host_rdata_o[%h]", addr), rec_vals[r][3][i], host_rdata);
    end
  endtask

  // Port 2 in a record pulses both ports, port 0 must win
  task automatic run_job(input int r);
    int port;
    int other;
    int lat;
    int used;
    bit smpl;
    bit finished;
    logic [1:0] mask;
    logic [1:0] dv_next;
    port  = (rec_port[r] == 2'd2) ? 0 : int'(rec_port[r]);
    other = 1 - port;
    mask  = 2'b01 << port;
    smpl  = rec_mode[r] inside {ntt_ctrl_pkg::MODE_PWM_SMPL, ntt_ctrl_pkg::MODE_PWM_ACCUM_SMPL};
    @(posedge clk);
    ntt_enable      <= (rec_port[r] == 2'd2) ? 2'b11 : mask;
    ntt_mode[port]  <= rec_mode[r];
    ntt_base[port]  <= rec_a[r];
    pwo_base[port]  <= rec_b[r];
    ntt_mode[other] <= ntt_ctrl_pkg::MODE_PWA;
    ntt_base[other] <= '0;
    pwo_base[other] <= '0;
    sampler_data    <= rec_vals[r][1][0];
    lat      = 0;
    used     = 0;
    finished = 1'b0;
    while (!finished) begin
      @(posedge clk);
      // Sampled values here belong to cycle lat after the enable
      check_status("ntt_busy_o", (lat >= 2) ? mask : 2'b00, ntt_busy);
      if (ntt_done != 2'b00) begin
        check_status("ntt_done_o", mask, ntt_done);
        if (!smpl) check_latency("ntt_done_o latency", JOB_LATENCY, lat);
        finished = 1'b1;
      end
      if (smpl && ntt_busy[port] && sampler_dv[port]) used++;
      // Second request in mid-job, must be dropped
      ntt_enable <= (lat == 4) ? (2'b01 << other) : 2'b00;
      dv_next = 2'($urandom);
      if (smpl) dv_next[port] = (used < ntt_params_pkg::POLY_N) && (($urandom % 3) != 0);
      sampler_dv <= dv_next;
      if (used < ntt_params_pkg::POLY_N) sampler_data <= rec_vals[r][1][used];
      lat++;
    end
    repeat (4) begin
      @(posedge clk);
      sampler_dv <= 2'b00;
      check_status("ntt_busy_o", 2'b00, ntt_busy);
      check_status("ntt_done_o", 2'b00, ntt_done);
    end
  endtask

  initial begin
    wait (records_ready);
    repeat (RESET_CYCLES + num_rec * CYCLES_PER_REC) @(posedge clk);
    stop_with_error($sformatf("timeout: run did not finish within %0d cycles",
                              RESET_CYCLES + num_rec * CYCLES_PER_REC));
  end

  initial begin
    int r;
    bit smpl;
    void'($urandom(32'hfaab5069));
    reset_n      = 1'b0;
    ntt_enable   = 2'b00;
    ntt_mode[0]  = ntt_ctrl_pkg::MODE_NONE;
    ntt_mode[1]  = ntt_ctrl_pkg::MODE_NONE;
    ntt_base     = '0;
    pwo_base     = '0;
    sampler_dv   = 2'b00;
    sampler_data = '0;
    host_we      = 1'b0;
    host_re      = 1'b0;
    host_addr    = '0;
    host_wdata   = '0;
    load_records();
    records_ready = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    reset_n <= 1'b1;
    for (r = 0; r < num_rec; r++) begin
      smpl = rec_mode[r] inside {ntt_ctrl_pkg::MODE_PWM_SMPL,
                                 ntt_ctrl_pkg::MODE_PWM_ACCUM_SMPL};
      load_region(rec_a[r], r, 0, 1'b0);
      // B region cleared in sampler modes so memory reads would show up
      load_region(rec_b[r], r, 1, smpl);
      load_region(rec_b[r] + ntt_params_pkg::DEST_OFFSET, r, 2, 1'b0);
      run_job(r);
      check_region(r);
    end
    if (dut_i.checker_i.fail_count != 0) begin
      stop_with_error("protocol assertions failed during the run");
    end else begin
      $display("NO ERRORS");
      $finish;
    end
  end

endmodule

// File: test/ntt_subsystem_checker.sv
// *************************************************************************
// Protocol assertions for the shared polynomial unit top level
//   Busy and done ownership, single-cycle done, engine writes
//   Bound into the top level
// *************************************************************************

`timescale 1ns/100ps

module ntt_subsystem_checker (
  input  logic       clk,
  input  logic       reset_n,
  input  logic [1:0] ntt_busy_i,
  input  logic [1:0] ntt_done_i,
  input  logic       wr_en_i,
  input  logic       engine_busy_i
);

  int fail_count = 0;

  // Only one port may own the engine
  one_owner_a: assert property (@(posedge clk) disable iff (!reset_n)
    !(&ntt_busy_i) && !(&ntt_done_i))
    else begin
      $error("busy or done high on both ports");
      fail_count++;
    end

  done_pulse_a: assert property (@(posedge clk) disable iff (!reset_n)
    |ntt_done_i |=> ntt_done_i == 2'b00)
    else begin
      $error("done held longer than one cycle");
      fail_count++;
    end

  // Done comes in the last busy cycle
  done_busy_a: assert property (@(posedge clk) disable iff (!reset_n)
    (ntt_done_i & ~ntt_busy_i) == 2'b00)
    else begin
      $error("done without busy on the same port");
      fail_count++;
    end

  idle_write_a: assert property (@(posedge clk) disable iff (!reset_n)
    wr_en_i |-> engine_busy_i)
    else begin
      $error("engine write while the engine is idle");
      fail_count++;
    end

endmodule

bind ntt_subsystem_top ntt_subsystem_checker checker_i (
  .clk           (clk),
  .reset_n       (reset_n),
  .ntt_busy_i    (ntt_busy_o),
  .ntt_done_i    (ntt_done_o),
  .wr_en_i       (wr_en),
  .engine_busy_i (engine_busy)
);

// File: hw/ntt_subsystem_top.sv
// *************************************************************************
// Top level of the shared pointwise polynomial unit
//   Arbiter for two controller ports, coefficient memory and engine
// *************************************************************************

`timescale 1ns/100ps

module ntt_subsystem_top (
  input  logic                            clk,
  input  logic                            reset_n,
  input  logic [1:0]                      ntt_enable_i,
  input  ntt_ctrl_pkg::ntt_mode_e [1:0]   ntt_mode_i,
  input  ntt_params_pkg::mem_addr_t [1:0] ntt_base_i,
  input  ntt_params_pkg::mem_addr_t [1:0] pwo_base_i,
  input  logic [1:0]                      sampler_dv_i,
  input  ntt_params_pkg::coeff_t          sampler_data_i,
  output logic [1:0]                      ntt_busy_o,
  output logic [1:0]                      ntt_done_o,
  input  logic                            host_we_i,
  input  logic                            host_re_i,
  input  ntt_params_pkg::mem_addr_t       host_addr_i,
  input  ntt_params_pkg::coeff_t          host_wdata_i,
  output ntt_params_pkg::coeff_t          host_rdata_o
);

  logic                      engine_start;
  logic                      engine_busy;
  logic                      engine_done;
  ntt_ctrl_pkg::engine_op_e  engine_op;
  logic                      accumulate;
  logic                      smpl_mode;
  logic                      smpl_valid;
  ntt_params_pkg::mem_addr_t a_base;
  ntt_params_pkg::mem_addr_t b_base;

  // Engine to memory
  logic [2:0]                rd_en;
  ntt_params_pkg::mem_addr_t rd_addr_a;
  ntt_params_pkg::mem_addr_t rd_addr_b;
  ntt_params_pkg::mem_addr_t rd_addr_d;
  ntt_params_pkg::coeff_t    rd_data_a;
  ntt_params_pkg::coeff_t    rd_data_b;
  ntt_params_pkg::coeff_t    rd_data_d;
  logic                      wr_en;
  ntt_params_pkg::mem_addr_t wr_addr;
  ntt_params_pkg::coeff_t    wr_data;

  ntt_share_arbiter arbiter_i (
    .clk            (clk),
    .reset_n        (reset_n),
    .ntt_enable_i   (ntt_enable_i),
    .ntt_mode_i     (ntt_mode_i),
    .ntt_base_i     (ntt_base_i),
    .pwo_base_i     (pwo_base_i),
    .sampler_dv_i   (sampler_dv_i),
    .engine_busy_i  (engine_busy),
    .engine_done_i  (engine_done),
    .ntt_busy_o     (ntt_busy_o),
    .ntt_done_o     (ntt_done_o),
    .engine_start_o (engine_start),
    .engine_op_o    (engine_op),
    .accumulate_o   (accumulate),
    .smpl_mode_o    (smpl_mode),
    .smpl_valid_o   (smpl_valid),
    .a_base_o       (a_base),
    .b_base_o       (b_base)
  );

  poly_mem mem_i (
    .clk          (clk),
    .reset_n      (reset_n),
    .rd_en_i      (rd_en),
    .rd_addr_a_i  (rd_addr_a),
    .rd_addr_b_i  (rd_addr_b),
    .rd_addr_d_i  (rd_addr_d),
    .rd_data_a_o  (rd_data_a),
    .rd_data_b_o  (rd_data_b),
    .rd_data_d_o  (rd_data_d),
    .wr_en_i      (wr_en),
    .wr_addr_i    (wr_addr),
    .wr_data_i    (wr_data),
    .host_we_i    (host_we_i),
    .host_re_i    (host_re_i),
    .host_addr_i  (host_addr_i),
    .host_wdata_i (host_wdata_i),
    .host_rdata_o (host_rdata_o)
  );

  pointwise_engine engine_i (
    .clk          (clk),
    .reset_n      (reset_n),
    .start_i      (engine_start),
    .op_i         (engine_op),
    .accumulate_i (accumulate),
    .smpl_mode_i  (smpl_mode),
    .smpl_valid_i (smpl_valid),
    .smpl_data_i  (sampler_data_i),
    .a_base_i     (a_base),
    .b_base_i     (b_base),
    .busy_o       (engine_busy),
    .done_o       (engine_done),
    .rd_en_o      (rd_en),
    .rd_addr_a_o  (rd_addr_a),
    .rd_addr_b_o  (rd_addr_b),
    .rd_addr_d_o  (rd_addr_d),
    .rd_data_a_i  (rd_data_a),
    .rd_data_b_i  (rd_data_b),
    .rd_data_d_i  (rd_data_d),
    .wr_en_o      (wr_en),
    .wr_addr_o    (wr_addr),
    .wr_data_o    (wr_data)
  );

endmodule

// File: hw/pointwise_engine.sv
// *************************************************************************
// Pointwise polynomial engine
//   FSM with index counter driving the read stage
//   Write stage doing modular multiply, add or subtract
//   Optional accumulate onto the old destination word
//   Operand B from the sampler stream in sampler modes
// *************************************************************************

`timescale 1ns/100ps

module pointwise_engine (
  input  logic                      clk,
  input  logic                      reset_n,
  input  logic                      start_i,
  input  ntt_ctrl_pkg::engine_op_e  op_i,
  input  logic                      accumulate_i,
  input  logic                      smpl_mode_i,
  input  logic                      smpl_valid_i,
  input  ntt_params_pkg::coeff_t    smpl_data_i,
  input  ntt_params_pkg::mem_addr_t a_base_i,
  input  ntt_params_pkg::mem_addr_t b_base_i,
  output logic                      busy_o,
  output logic                      done_o,
  output logic [2:0]                rd_en_o,
  output ntt_params_pkg::mem_addr_t rd_addr_a_o,
  output ntt_params_pkg::mem_addr_t rd_addr_b_o,
  output ntt_params_pkg::mem_addr_t rd_addr_d_o,
  input  ntt_params_pkg::coeff_t    rd_data_a_i,
  input  ntt_params_pkg::coeff_t    rd_data_b_i,
  input  ntt_params_pkg::coeff_t    rd_data_d_i,
  output logic                      wr_en_o,
  output ntt_params_pkg::mem_addr_t wr_addr_o,
  output ntt_params_pkg::coeff_t    wr_data_o
);

  ntt_ctrl_pkg::engine_state_e state_q;
  ntt_params_pkg::idx_t        idx_q;
  ntt_params_pkg::idx_t        s2_idx_q;
  logic                        s2_valid_q;
  ntt_params_pkg::coeff_t      smpl_q;
  logic                        advance;
  ntt_params_pkg::coeff_t      operand_b;
  ntt_params_pkg::prod_t       product;
  ntt_params_pkg::coeff_t      op_res;

  function automatic ntt_params_pkg::coeff_t mod_add(ntt_params_pkg::coeff_t x,
                                                     ntt_params_pkg::coeff_t y);
    logic [ntt_params_pkg::COEFF_W:0] s;
    s = {1'b0, x} + {1'b0, y};
    if (s >= {1'b0, ntt_params_pkg::Q}) s = s - {1'b0, ntt_params_pkg::Q};
    return s[ntt_params_pkg::COEFF_W-1:0];
  endfunction

  // Wraps below zero back into 0 .. Q-1
  function automatic ntt_params_pkg::coeff_t mod_sub(ntt_params_pkg::coeff_t x,
                                                     ntt_params_pkg::coeff_t y);
    if (x >= y) return x - y;
    return x + (ntt_params_pkg::Q - y);
  endfunction

  // Read stage holds while the sampler has no coefficient
  assign advance = (state_q == ntt_ctrl_pkg::RUN) && (!smpl_mode_i || smpl_valid_i);

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state_q    <= ntt_ctrl_pkg::IDLE;
      idx_q      <= '0;
      s2_valid_q <= 1'b0;
    end else begin
      s2_valid_q <= advance;
      case (state_q)
        ntt_ctrl_pkg::IDLE: begin
          idx_q <= '0;
          if (start_i) state_q <= ntt_ctrl_pkg::RUN;
        end
        ntt_ctrl_pkg::RUN: begin
          if (advance) begin
            idx_q <= idx_q + 1'b1;
            if (idx_q == ntt_params_pkg::idx_t'(ntt_params_pkg::POLY_N - 1)) begin
              state_q <= ntt_ctrl_pkg::DRAIN;
            end
          end
        end
        // Last write goes out, then a cycle for done
        ntt_ctrl_pkg::DRAIN: if (!s2_valid_q) state_q <= ntt_ctrl_pkg::IDLE;
        default: state_q <= ntt_ctrl_pkg::IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      s2_idx_q <= idx_q;
      if (smpl_mode_i) smpl_q <= smpl_data_i;
    end
  end

  assign busy_o = (state_q != ntt_ctrl_pkg::IDLE);
  assign done_o = (state_q == ntt_ctrl_pkg::DRAIN) && !s2_valid_q;

  // Port order is A, B, old destination
  assign rd_en_o     = {advance && accumulate_i, advance && !smpl_mode_i, advance};
  assign rd_addr_a_o = a_base_i + ntt_params_pkg::mem_addr_t'(idx_q);
  assign rd_addr_b_o = b_base_i + ntt_params_pkg::mem_addr_t'(idx_q);
  assign rd_addr_d_o = b_base_i + ntt_params_pkg::DEST_OFFSET +
                       ntt_params_pkg::mem_addr_t'(idx_q);

  always_comb begin
    operand_b = smpl_mode_i ? smpl_q : rd_data_b_i;
    product   = ntt_params_pkg::prod_t'(rd_data_a_i) * ntt_params_pkg::prod_t'(operand_b);
    case (op_i)
      ntt_ctrl_pkg::OP_ADD: op_res = mod_add(rd_data_a_i, operand_b);
      ntt_ctrl_pkg::OP_SUB: op_res = mod_sub(rd_data_a_i, operand_b);
      default: op_res = ntt_params_pkg::coeff_t'(product %
                                                 ntt_params_pkg::prod_t'(ntt_params_pkg::Q));
    endcase
    wr_data_o = accumulate_i ? mod_add(op_res, rd_data_d_i) : op_res;
  end

  assign wr_en_o   = s2_valid_q;
  assign wr_addr_o = b_base_i + ntt_params_pkg::DEST_OFFSET +
                     ntt_params_pkg::mem_addr_t'(s2_idx_q);

endmodule

// File: hw/poly_mem.sv
// *************************************************************************
// Coefficient memory of the shared polynomial unit
//   Register array with three registered read ports and one write port
//   Host port sharing the write port and the destination read port
// *************************************************************************

`timescale 1ns/100ps

module poly_mem (
  input  logic                      clk,
  input  logic                      reset_n,
  input  logic [2:0]                rd_en_i,
  input  ntt_params_pkg::mem_addr_t rd_addr_a_i,
  input  ntt_params_pkg::mem_addr_t rd_addr_b_i,
  input  ntt_params_pkg::mem_addr_t rd_addr_d_i,
  output ntt_params_pkg::coeff_t    rd_data_a_o,
  output ntt_params_pkg::coeff_t    rd_data_b_o,
  output ntt_params_pkg::coeff_t    rd_data_d_o,
  input  logic                      wr_en_i,
  input  ntt_params_pkg::mem_addr_t wr_addr_i,
  input  ntt_params_pkg::coeff_t    wr_data_i,
  input  logic                      host_we_i,
  input  logic                      host_re_i,
  input  ntt_params_pkg::mem_addr_t host_addr_i,
  input  ntt_params_pkg::coeff_t    host_wdata_i,
  output ntt_params_pkg::coeff_t    host_rdata_o
);

  ntt_params_pkg::coeff_t    mem_q [ntt_params_pkg::MEM_DEPTH];
  ntt_params_pkg::coeff_t    d_q;
  ntt_params_pkg::mem_addr_t d_addr;

  // Engine has the write port, host fills in when it is free
  always_ff @(posedge clk) begin
    if (wr_en_i) begin
      mem_q[wr_addr_i] <= wr_data_i;
    end else if (host_we_i) begin
      mem_q[host_addr_i] <= host_wdata_i;
    end
  end

  assign d_addr = rd_en_i[2] ? rd_addr_d_i : host_addr_i;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      rd_data_a_o <= '0;
      rd_data_b_o <= '0;
      d_q         <= '0;
    end else begin
      if (rd_en_i[0]) rd_data_a_o <= mem_q[rd_addr_a_i];
      if (rd_en_i[1]) rd_data_b_o <= mem_q[rd_addr_b_i];
      if (rd_en_i[2] || host_re_i) d_q <= mem_q[d_addr];
    end
  end

  assign rd_data_d_o  = d_q;
  assign host_rdata_o = d_q;

endmodule

// File: hw/ntt_share_arbiter.sv
// *************************************************************************
// Sharing arbiter for two controller ports
//   Accepts one start pulse at a time, port 0 first
//   Latches the owner, the mode and both base addresses
//   Decodes the mode into engine operation and sampler rules
//   Routes engine busy and done back to the owning port
// *************************************************************************

`timescale 1ns/100ps

module ntt_share_arbiter (
  input  logic                              clk,
  input  logic                              reset_n,
  input  logic [1:0]                        ntt_enable_i,
  input  ntt_ctrl_pkg::ntt_mode_e [1:0]     ntt_mode_i,
  input  ntt_params_pkg::mem_addr_t [1:0]   ntt_base_i,
  input  ntt_params_pkg::mem_addr_t [1:0]   pwo_base_i,
  input  logic [1:0]                        sampler_dv_i,
  input  logic                              engine_busy_i,
  input  logic                              engine_done_i,
  output logic [1:0]                        ntt_busy_o,
  output logic [1:0]                        ntt_done_o,
  output logic                              engine_start_o,
  output ntt_ctrl_pkg::engine_op_e          engine_op_o,
  output logic                              accumulate_o,
  output logic                              smpl_mode_o,
  output logic                              smpl_valid_o,
  output ntt_params_pkg::mem_addr_t         a_base_o,
  output ntt_params_pkg::mem_addr_t         b_base_o
);

  logic                      sel;
  logic                      accept;
  logic                      owner_q;
  logic                      start_q;
  ntt_ctrl_pkg::ntt_mode_e   mode_q;
  ntt_params_pkg::mem_addr_t a_base_q;
  ntt_params_pkg::mem_addr_t b_base_q;

  // Port 1 only gets in when port 0 is quiet
  assign sel = ~ntt_enable_i[0];

  // Requests during a job or with no mode are dropped
  assign accept = (|ntt_enable_i) && (ntt_mode_i[sel] != ntt_ctrl_pkg::MODE_NONE) &&
                  !engine_busy_i && !start_q;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      owner_q <= 1'b0;
      start_q <= 1'b0;
      mode_q  <= ntt_ctrl_pkg::MODE_NONE;
    end else begin
      start_q <= accept;
      if (accept) begin
        owner_q <= sel;
        mode_q  <= ntt_mode_i[sel];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      a_base_q <= ntt_base_i[sel];
      b_base_q <= pwo_base_i[sel];
    end
  end

  assign engine_start_o = start_q;
  assign a_base_o       = a_base_q;
  assign b_base_o       = b_base_q;

  // Mode decode, sampler valid only matters for the owner
  always_comb begin
    engine_op_o  = ntt_ctrl_pkg::OP_MUL;
    accumulate_o = 1'b0;
    smpl_mode_o  = 1'b0;
    smpl_valid_o = 1'b1;
    case (mode_q)
      ntt_ctrl_pkg::MODE_PWM_ACCUM: accumulate_o = 1'b1;
      ntt_ctrl_pkg::MODE_PWM_SMPL: begin
        smpl_mode_o  = 1'b1;
        smpl_valid_o = sampler_dv_i[owner_q];
      end
      ntt_ctrl_pkg::MODE_PWM_ACCUM_SMPL: begin
        accumulate_o = 1'b1;
        smpl_mode_o  = 1'b1;
        smpl_valid_o = sampler_dv_i[owner_q];
      end
      ntt_ctrl_pkg::MODE_PWA: engine_op_o = ntt_ctrl_pkg::OP_ADD;
      ntt_ctrl_pkg::MODE_PWS: engine_op_o = ntt_ctrl_pkg::OP_SUB;
      default: ;
    endcase
  end

  // Status goes only to the port that owns the job
  always_comb begin
    ntt_busy_o          = 2'b00;
    ntt_done_o          = 2'b00;
    ntt_busy_o[owner_q] = engine_busy_i;
    ntt_done_o[owner_q] = engine_done_i;
  end

endmodule

// File: hw/ntt_ctrl_pkg.sv
// *************************************************************************
// Control encodings of the shared polynomial unit
//   Controller mode, engine operation and engine FSM states
// *************************************************************************

package ntt_ctrl_pkg;

  typedef enum logic [2:0] {
    MODE_NONE           = 3'd0,
    MODE_PWM            = 3'd1,
    MODE_PWM_ACCUM      = 3'd2,
    MODE_PWM_SMPL       = 3'd3,
    MODE_PWM_ACCUM_SMPL = 3'd4,
    MODE_PWA            = 3'd5,
    MODE_PWS            = 3'd6
  } ntt_mode_e;

  typedef enum logic [1:0] {
    OP_MUL = 2'd0,
    OP_ADD = 2'd1,
    OP_SUB = 2'd2
  } engine_op_e;

  typedef enum logic [1:0] {
    IDLE  = 2'd0,
    RUN   = 2'd1,
    DRAIN = 2'd2
  } engine_state_e;

endpackage

// File: hw/ntt_params_pkg.sv
// *************************************************************************
// Sizes and number formats of the shared polynomial unit
//   Coefficient, product, index and memory address widths
//   Polynomial length, memory depth and destination offset
//   The modulus Q
// *************************************************************************

package ntt_params_pkg;

  localparam int COEFF_W = 23;
  localparam int POLY_N = 8;
  localparam int MEM_DEPTH = 64;
  localparam int ADDR_W = $clog2(MEM_DEPTH);
  localparam int IDX_W = $clog2(POLY_N);

  typedef logic [COEFF_W-1:0] coeff_t;
  typedef logic [2*COEFF_W-1:0] prod_t;
  typedef logic [ADDR_W-1:0] mem_addr_t;
  typedef logic [IDX_W-1:0] idx_t;

  // Destination region sits right after the pwo operand
  localparam mem_addr_t DEST_OFFSET = mem_addr_t'(POLY_N);

  // ML-DSA prime, 2^23 - 2^13 + 1
  localparam coeff_t Q = 23'd8380417;

endpackage
